// File: hw/err_inj_regs.sv
`timescale 1ns/100ps

module err_inj_regs
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  tlp_err_pkg::wb_req_t    wb_req,
  output tlp_err_pkg::wb_rsp_t    wb_rsp,
  output tlp_err_pkg::fault_vec_t fault_en,
  input  logic                    inj_pulse
);
  import tlp_err_pkg::*;

  logic        ack_q;
  logic [31:0] rd_data;
  logic [31:0] inj_count;
  fault_vec_t  fault_en_q;
  logic        access;
  logic        wr_en;
  logic [31:0] rd_mux;

  // An access is taken only when ack was low, giving the one idle cycle
  assign access = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr_en  = access && wb_req.we;

  // ========================================
  // Read mux
  // ========================================
  always_comb
  begin
    // Unmapped words read as zero
    rd_mux = 32'd0;
    case (wb_req.adr)
      reg_fault_en:  rd_mux = {21'd0, fault_en_q};
      reg_inj_count: rd_mux = inj_count;
      default:       rd_mux = 32'd0;
    endcase
  end

  // ========================================
  // Bus handshake and registers
  // ========================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack_q      <= 1'b0;
      fault_en_q <= '0;
      inj_count  <= 32'd0;
    end
    else
    begin
      ack_q <= access;
      if (wr_en && (wb_req.adr == reg_fault_en))
      begin
        fault_en_q <= wb_req.dat[10:0];
      end
      // A write to the counter clears it, and it wins over a pulse
      if (wr_en && (wb_req.adr == reg_inj_count))
      begin
        inj_count <= 32'd0;
      end
      else if (inj_pulse && (inj_count != 32'hFFFF_FFFF))
      begin
        inj_count <= inj_count + 32'd1;
      end
    end
  end

  // Read data is captured on the edge that raises ack
  always_ff @(posedge clk)
  begin
    if (access)
    begin
      rd_data <= rd_mux;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rd_data;
  assign fault_en   = fault_en_q;

endmodule

// File: hw/tlp_err_inject.sv
`timescale 1ns/100ps

module tlp_err_inject
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    q_valid,
  output logic                    q_ready,
  input  tlp_err_pkg::tlp_beat_t  q_beat,
  output logic                    link_valid,
  input  logic                    link_ready,
  output tlp_err_pkg::tlp_beat_t  link_beat,
  input  tlp_err_pkg::fault_vec_t fault_en,
  output logic                    inj_pulse
);
  import tlp_err_pkg::*;

  // Packet tracking state
  logic         sop;
  logic         in_drop;
  // Replay state, armed during a completion and pending after its last beat
  logic         rep_armed;
  logic         rep_pend;
  logic         rep_hold;
  logic [127:0] rep_data;

  tlp_hdr_u     hdr_in;
  tlp_hdr_u     hdr_out;
  tlp_beat_t    mod_beat;
  logic         is_mwr;
  logic         is_mrd;
  logic         is_cpl;
  logic         hdr_changed;
  logic         drop_now;
  logic         arm_now;
  logic         rep_show;
  logic         q_fire;
  logic         send_fire;
  logic         rep_fire;

  // ========================================
  // Header classification
  // ========================================

  // The decode is only meaningful while sop is high
  always_comb
  begin
    hdr_in = q_beat.data[63:0];
    is_mwr = (hdr_in.req.fmt_type == fmt_mwr);
    is_mrd = (hdr_in.req.fmt_type == fmt_mrd);
    is_cpl = (hdr_in.cpl.fmt_type == fmt_cpl) || (hdr_in.cpl.fmt_type == fmt_cpld);
  end

  // A completion is dropped as a whole, decided at its header beat
  assign drop_now = sop ? (is_cpl && fault_en.cpl_drop) : in_drop;

  // A dropped completion is never replayed since nothing of it was sent
  assign arm_now = sop ? (is_cpl && fault_en.cpl_replay && !fault_en.cpl_drop) : rep_armed;

  // ========================================
  // Header rewrites
  // ========================================

  // Each enabled fault writes from the original field, so later bits win
  always_comb
  begin
    hdr_out = hdr_in;
    if (is_mwr)
    begin
      if (fault_en.mwr_short)
        hdr_out.req.length = hdr_in.req.length - 10'd1;
      if (fault_en.mwr_long)
        hdr_out.req.length = hdr_in.req.length + 10'd1;
      if (fault_en.mwr_oversize)
        hdr_out.req.length = len_oversize;
    end
    if (is_mrd)
    begin
      if (fault_en.mrd_oversize)
        hdr_out.req.length = len_oversize;
      if (fault_en.tag_reuse)
        hdr_out.req.tag = tag_in_use;
      if (fault_en.tag_max)
        hdr_out.req.tag = tag_over_max;
    end
    if (is_cpl)
    begin
      if (fault_en.cpl_bc_short)
        hdr_out.cpl.byte_count = hdr_in.cpl.byte_count - cpl_bc_short_step;
      if (fault_en.cpl_len_short)
        hdr_out.cpl.length = hdr_in.cpl.length - 10'd1;
    end
    // Malformed TLP applies to every header regardless of its class
    if (fault_en.bad_fmt)
      hdr_out.req.fmt_type = fmt_bad;
  end

  // Payload beats pass untouched, only the header word is swapped
  always_comb
  begin
    mod_beat = q_beat;
    if (sop)
    begin
      mod_beat.data[63:0] = hdr_out;
    end
  end

  assign hdr_changed = (hdr_out != hdr_in);

  // ========================================
  // Output selection
  // ========================================

  // The replay goes out in a gap, and once shown it stays until taken
  assign rep_show = rep_pend && (!q_valid || rep_hold);

  always_comb
  begin
    if (rep_show)
    begin
      link_valid     = 1'b1;
      link_beat.data = rep_data;
      link_beat.last = 1'b1;
      q_ready        = 1'b0;
    end
    else
    begin
      // Dropped beats are sunk here at full rate
      link_valid = q_valid && !drop_now;
      link_beat  = mod_beat;
      q_ready    = drop_now || link_ready;
    end
  end

  assign q_fire    = q_valid && q_ready;
  assign send_fire = q_fire && !drop_now;
  assign rep_fire  = rep_show && link_ready;

  // One strobe per changed header, per dropped completion, per replay sent
  assign inj_pulse = (send_fire && sop && hdr_changed) ||
                     (q_fire && sop && drop_now) ||
                     rep_fire;

  // ========================================
  // State update
  // ========================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sop       <= 1'b1;
      in_drop   <= 1'b0;
      rep_armed <= 1'b0;
      rep_pend  <= 1'b0;
      rep_hold  <= 1'b0;
    end
    else
    begin
      if (q_fire)
      begin
        // The beat after a last opens the next packet
        sop     <= q_beat.last;
        in_drop <= drop_now && !q_beat.last;
      end
      if (send_fire)
      begin
        rep_armed <= arm_now && !q_beat.last;
      end
      if (rep_fire)
      begin
        rep_pend <= 1'b0;
      end
      else if (send_fire && arm_now && q_beat.last)
      begin
        rep_pend <= 1'b1;
      end
      rep_hold <= rep_show && !link_ready;
    end
  end

  // Copy of the completion header as it went out on the link
  always_ff @(posedge clk)
  begin
    if (send_fire && sop && arm_now)
    begin
      rep_data <= mod_beat.data;
    end
  end

endmodule

// File: hw/tlp_err_pkg.sv
package tlp_err_pkg;

  // ========================================
  // Stream beat
  // ========================================

  // The TLP header rides in data[63:0] on the first beat of a packet
  typedef struct packed {
    logic [127:0] data;
    logic         last;
  } tlp_beat_t;

  // ========================================
  // Header layouts
  // ========================================

  // Request view, used for memory reads and memory writes
  typedef struct packed {
    logic [7:0]  fmt_type;
    logic [9:0]  tag;
    logic [9:0]  length;
    logic [3:0]  rsvd;
    logic [31:0] addr;
  } tlp_req_hdr_t;

  // Completion view, byte_count counts the bytes still owed to the requester
  typedef struct packed {
    logic [7:0]  fmt_type;
    logic [9:0]  tag;
    logic [9:0]  length;
    logic [11:0] byte_count;
    logic [15:0] cpl_id;
    logic [7:0]  low_addr_status;
  } tlp_cpl_hdr_t;

  // fmt_type sits in the same place in both views, so it selects the view
  typedef union packed {
    tlp_req_hdr_t req;
    tlp_cpl_hdr_t cpl;
  } tlp_hdr_u;

  // Format and type codes
  localparam logic [7:0] fmt_mwr  = 8'h40;
  localparam logic [7:0] fmt_mrd  = 8'h00;
  localparam logic [7:0] fmt_cpl  = 8'h0A;
  localparam logic [7:0] fmt_cpld = 8'h4A;
  localparam logic [7:0] fmt_bad  = 8'h43;

  // Values forced into headers by the faults
  localparam logic [9:0]  tag_in_use        = 10'd2;
  localparam logic [9:0]  tag_over_max      = 10'h221;
  localparam logic [9:0]  len_oversize      = 10'd136;
  localparam logic [11:0] cpl_bc_short_step = 12'd4;

  // ========================================
  // Fault enables and register map
  // ========================================

  // Declared from the top bit down, so mwr_short lands on bit 0
  typedef struct packed {
    logic bad_fmt;
    logic cpl_replay;
    logic cpl_drop;
    logic cpl_len_short;
    logic cpl_bc_short;
    logic tag_max;
    logic tag_reuse;
    logic mrd_oversize;
    logic mwr_oversize;
    logic mwr_long;
    logic mwr_short;
  } fault_vec_t;

  // Wishbone classic request, adr is a word address
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
  } wb_rsp_t;

  localparam logic [3:0] reg_fault_en  = 4'd0;
  localparam logic [3:0] reg_inj_count = 4'd1;

endpackage

// File: hw/tlp_err_top.sv
`timescale 1ns/100ps

module tlp_err_top
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  tlp_err_pkg::wb_req_t   wb_req,
  output tlp_err_pkg::wb_rsp_t   wb_rsp,
  input  logic                   afu_valid,
  output logic                   afu_ready,
  input  tlp_err_pkg::tlp_beat_t afu_beat,
  output logic                   link_valid,
  input  logic                   link_ready,
  output tlp_err_pkg::tlp_beat_t link_beat
);
  import tlp_err_pkg::*;

  // Registered stream between the slice and the injector
  logic       q_valid;
  logic       q_ready;
  tlp_beat_t  q_beat;
  // Side band between the injector and the register block
  fault_vec_t fault_en;
  logic       inj_pulse;

  // ========================================
  // Stream path
  // ========================================
  tlp_tx_slice u_slice (
    .clk       (clk),
    .rst_n     (rst_n),
    .afu_valid (afu_valid),
    .afu_ready (afu_ready),
    .afu_beat  (afu_beat),
    .q_valid   (q_valid),
    .q_ready   (q_ready),
    .q_beat    (q_beat)
  );

  tlp_err_inject u_inject (
    .clk        (clk),
    .rst_n      (rst_n),
    .q_valid    (q_valid),
    .q_ready    (q_ready),
    .q_beat     (q_beat),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link_beat  (link_beat),
    .fault_en   (fault_en),
    .inj_pulse  (inj_pulse)
  );

  // Control registers on the Wishbone side
  err_inj_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .fault_en  (fault_en),
    .inj_pulse (inj_pulse)
  );

endmodule

// File: hw/tlp_tx_slice.sv
`timescale 1ns/100ps

module tlp_tx_slice
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   afu_valid,
  output logic                   afu_ready,
  input  tlp_err_pkg::tlp_beat_t afu_beat,
  output logic                   q_valid,
  input  logic                   q_ready,
  output tlp_err_pkg::tlp_beat_t q_beat
);
  import tlp_err_pkg::*;

  // Occupied flag for the single entry
  logic      full;
  // Goes high on the first edge after reset, keeps the AFU stalled until then
  logic      live;
  tlp_beat_t beat_q;

  // Room exists when empty, or when the held beat leaves this cycle
  assign afu_ready = live && (!full || q_ready);

  assign q_valid = full;
  assign q_beat  = beat_q;

  // ========================================
  // Control state
  // ========================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full <= 1'b0;
      live <= 1'b0;
    end
    else
    begin
      live <= 1'b1;
      // A refill and a drain in the same cycle keep the entry occupied
      if (afu_ready)
      begin
        full <= afu_valid;
      end
    end
  end

  // The beat itself is loaded only on an accepted transfer
  always_ff @(posedge clk)
  begin
    if (afu_valid && afu_ready)
    begin
      beat_q <= afu_beat;
    end
  end

endmodule

// File: project.f
hw/tlp_err_pkg.sv
hw/tlp_tx_slice.sv
hw/tlp_err_inject.sv
hw/err_inj_regs.sv
hw/tlp_err_top.sv
verif/tb_clk_gen.sv
verif/tlp_err_tb.sv

// File: verif/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen
(
  output logic clk,
  output logic rst_n
);

  localparam time half_period = 50;
  localparam int  reset_cycles = 8;

  // Free running clock with a 100 ns period
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(half_period) clk = ~clk;
    end
  end

  // Reset is released on a falling edge, half a cycle clear of the next rising edge
  initial
  begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: verif/tlp_err_tb.sv
`timescale 1ns/100ps

module tlp_err_tb;
  import tlp_err_pkg::*;

  // Packet budget of all tests, used to size the watchdog
  localparam int total_pkts      = 242;
  localparam int max_pkt_beats   = 4;
  localparam int watchdog_cycles = total_pkts * max_pkt_beats * 40 + 2000;

  logic       clk;
  logic       rst_n;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  logic       afu_valid;
  logic       afu_ready;
  tlp_beat_t  afu_beat;
  logic       link_valid;
  logic       link_ready;
  tlp_beat_t  link_beat;

  // Expected link beats in order, filled by the stimulus and drained by the checker
  tlp_beat_t  exp_q[$];
  fault_vec_t cur_en;
  int         exp_count;
  int         error_count;
  int         test_count;
  int         test_fail;
  int         err_at_start;
  int         beats_sent;
  int         pkt_wait_max;
  logic [15:0] data_lfsr;
  logic [15:0] stall_lfsr;
  logic        hold_low;
  logic        stall_b0;
  logic        stall_b1;
  logic        held;
  tlp_beat_t   held_beat;
  tlp_beat_t   want;
  logic [31:0] rd;
  fault_vec_t  en;

  tb_clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  tlp_err_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .afu_valid  (afu_valid),
    .afu_ready  (afu_ready),
    .afu_beat   (afu_beat),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link_beat  (link_beat)
  );

  // ========================================
  // Random source and reference model
  // ========================================

  // One step of a 16-bit Galois LFSR, the bit taken is the one shifted out
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], data_lfsr[0]};
      data_lfsr = lfsr_next(data_lfsr);
    end
    return r;
  endfunction

  function automatic logic is_completion(input logic [7:0] fmt);
    return (fmt == fmt_cpl) || (fmt == fmt_cpld);
  endfunction

  // Expected header after injection, higher fault bits take priority per field
  function automatic logic [63:0] expect_hdr(input logic [63:0] hdr, input fault_vec_t e);
    tlp_hdr_u h;
    logic [7:0] f;
    h = hdr;
    f = h.req.fmt_type;
    if (f == fmt_mwr)
    begin
      if (e.mwr_oversize)
        h.req.length = len_oversize;
      else if (e.mwr_long)
        h.req.length = h.req.length + 10'd1;
      else if (e.mwr_short)
        h.req.length = h.req.length - 10'd1;
    end
    else if (f == fmt_mrd)
    begin
      if (e.mrd_oversize)
        h.req.length = len_oversize;
      if (e.tag_max)
        h.req.tag = tag_over_max;
      else if (e.tag_reuse)
        h.req.tag = tag_in_use;
    end
    else if (is_completion(f))
    begin
      if (e.cpl_bc_short)
        h.cpl.byte_count = h.cpl.byte_count - cpl_bc_short_step;
      if (e.cpl_len_short)
        h.cpl.length = h.cpl.length - 10'd1;
    end
    if (e.bad_fmt)
      h.req.fmt_type = fmt_bad;
    return h;
  endfunction

  function automatic logic [7:0] random_fmt();
    case (rand_bits(2))
      0: return fmt_mwr;
      1: return fmt_mrd;
      2: return fmt_cpl;
      default: return fmt_cpld;
    endcase
  endfunction

  function automatic string fault_name(input int k);
    case (k)
      0: return "mwr_short";
      1: return "mwr_long";
      2: return "mwr_oversize";
      3: return "mrd_oversize";
      4: return "tag_reuse";
      5: return "tag_max";
      6: return "cpl_bc_short";
      7: return "cpl_len_short";
      default: return "bad_fmt";
    endcase
  endfunction

  task automatic report_error(input string msg);
    error_count++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // ========================================
  // Stream and bus drivers
  // ========================================

  // Entered on a falling edge and returns on the falling edge after the transfer
  task automatic drive_beat(input tlp_beat_t b);
    int waits;
    afu_valid = 1'b1;
    afu_beat  = b;
    waits     = 0;
    @(posedge clk);
    while (!afu_ready)
    begin
      waits++;
      @(posedge clk);
    end
    if (waits > pkt_wait_max)
      pkt_wait_max = waits;
    beats_sent++;
    @(negedge clk);
  endtask

  // Builds one packet, queues what the link should show and counts the injections
  task automatic send_packet(input logic [7:0] fmt, input int max_beats);
    tlp_beat_t   b;
    tlp_beat_t   e;
    tlp_beat_t   rep;
    logic [63:0] hdr;
    logic [63:0] hdr_exp;
    logic        drop;
    int          nb;
    hdr[63:32] = rand_bits(32);
    hdr[31:0]  = rand_bits(32);
    hdr[63:56] = fmt;
    nb = 1;
    // Reads and data-less completions are single beat
    if ((fmt == fmt_mwr || fmt == fmt_cpld) && max_beats > 1)
      nb = 1 + (rand_bits(2) % max_beats);
    hdr_exp = expect_hdr(hdr, cur_en);
    drop    = is_completion(fmt) && cur_en.cpl_drop;
    if (drop || hdr_exp != hdr)
      exp_count++;
    pkt_wait_max = 0;
    for (int i = 0; i < nb; i++)
    begin
      for (int w = 0; w < 4; w++)
        b.data[w*32 +: 32] = rand_bits(32);
      if (i == 0)
        b.data[63:0] = hdr;
      b.last = (i == nb - 1);
      e = b;
      if (i == 0)
      begin
        e.data[63:0] = hdr_exp;
        rep = e;
      end
      if (!drop)
        exp_q.push_back(e);
      // The replay copy follows the last beat and always carries last
      if (b.last && !drop && is_completion(fmt) && cur_en.cpl_replay)
      begin
        rep.last = 1'b1;
        exp_q.push_back(rep);
        exp_count++;
      end
      drive_beat(b);
    end
    afu_valid = 1'b0;
  endtask

  // Waits until every expected beat has left on the link
  task automatic wait_idle();
    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (3) @(negedge clk);
  endtask

  task automatic run_traffic(input int n, input int max_beats, input logic gap_each);
    for (int k = 0; k < n; k++)
    begin
      send_packet(random_fmt(), max_beats);
      if (gap_each)
        wait_idle();
      else if (rand_bits(1))
        @(negedge clk);
    end
  endtask

  // One Wishbone classic cycle, ack and read data are sampled on the falling edge
  task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int n;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    n = 1;
    @(negedge clk);
    while (!wb_rsp.ack && n < 20)
    begin
      n++;
      @(negedge clk);
    end
    assert (wb_rsp.ack)
    else
      report_error($sformatf("Wishbone access to word %0d got no ack", adr));
    rdat   = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic set_faults(input fault_vec_t e);
    logic [31:0] unused;
    wait_idle();
    wb_access(1'b1, reg_fault_en, {21'd0, e}, unused);
    cur_en = e;
  endtask

  // Compares the counter with the model, then clears it and reads zero back
  task automatic check_counter();
    logic [31:0] v;
    wait_idle();
    wb_access(1'b0, reg_inj_count, 32'd0, v);
    assert (v == exp_count)
    else
      report_error($sformatf("injection count 0x%h, expected 0x%h", v, exp_count));
    wb_access(1'b1, reg_inj_count, 32'd0, v);
    wb_access(1'b0, reg_inj_count, 32'd0, v);
    assert (v == 32'd0)
    else
      report_error($sformatf("injection count 0x%h after clear, expected 0", v));
    exp_count = 0;
  endtask

  task automatic start_test();
    err_at_start = error_count;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (error_count == err_at_start)
      $display("Test %s: PASS", name);
    else
    begin
      test_fail++;
      $display("Test %s: FAIL with %0d errors", name, error_count - err_at_start);
    end
  endtask

  // ========================================
  // Link side stall and compare processes
  // ========================================

  // Link back-pressure is low about one cycle in four
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      stall_b0   = stall_lfsr[0];
      stall_lfsr = lfsr_next(stall_lfsr);
      stall_b1   = stall_lfsr[0];
      stall_lfsr = lfsr_next(stall_lfsr);
      link_ready = hold_low ? 1'b0 : (stall_b0 | stall_b1);
    end
  end

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      // A stalled beat must stay on the link unchanged
      if (held)
      begin
        assert (link_valid && link_beat == held_beat)
        else
          report_error("link beat changed or dropped while link_ready was low");
      end
      if (link_valid && link_ready)
      begin
        assert (exp_q.size() != 0)
        else
          report_error($sformatf("unexpected link beat data %h", link_beat.data));
        if (exp_q.size() != 0)
        begin
          want = exp_q.pop_front();
          assert (link_beat == want)
          else
            report_error($sformatf("link beat %h last %b, expected %h last %b",
                                   link_beat.data, link_beat.last, want.data, want.last));
        end
      end
      held      = link_valid && !link_ready;
      held_beat = link_beat;
    end
  end

  // ========================================
  // Watchdog
  // ========================================
  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("Run timed out after %0d cycles, %0d beats still expected",
             watchdog_cycles, exp_q.size());
    $display("Done: errors found");
    $finish;
  end

  // ========================================
  // Test sequence
  // ========================================
  initial
  begin
    afu_valid   = 1'b0;
    afu_beat    = '0;
    link_ready  = 1'b0;
    wb_req      = '0;
    cur_en      = '0;
    hold_low    = 1'b0;
    held        = 1'b0;
    data_lfsr   = 16'd70;
    stall_lfsr  = 16'd70;
    exp_count   = 0;
    error_count = 0;
    test_count  = 0;
    test_fail   = 0;
    beats_sent  = 0;
    repeat (2) @(negedge clk);
    assert (!link_valid && !afu_ready && !wb_rsp.ack)
    else
      report_error("outputs are not idle during reset");
    wait (rst_n === 1'b1);
    @(negedge clk);

    // Clean traffic plus register map checks
    start_test();
    run_traffic(40, 4, 1'b0);
    wait_idle();
    wb_access(1'b1, 4'd5, 32'hFFFF_FFFF, rd);
    wb_access(1'b0, 4'd5, 32'd0, rd);
    assert (rd == 32'd0)
    else
      report_error($sformatf("unmapped word read 0x%h, expected 0", rd));
    wb_access(1'b0, reg_fault_en, 32'd0, rd);
    assert (rd == 32'd0)
    else
      report_error($sformatf("fault enables read 0x%h, expected 0", rd));
    wb_access(1'b1, reg_fault_en, 32'hA5A5_A5A5, rd);
    wb_access(1'b0, reg_fault_en, 32'd0, rd);
    assert (rd == 32'h0000_05A5)
    else
      report_error($sformatf("fault enables read 0x%h, expected 0x5a5", rd));
    set_faults('0);
    check_counter();
    finish_test("pass_through");

    // Header field faults, one enable at a time over mixed traffic
    for (int k = 0; k <= 10; k++)
    begin
      if (k == 8 || k == 9)
        continue;
      start_test();
      en = 11'd1 << k;
      set_faults(en);
      run_traffic(16, 4, 1'b0);
      check_counter();
      finish_test(fault_name(k));
    end

    // Completions vanish, then the slice must keep draining with the link stalled
    start_test();
    en = '0;
    en.cpl_drop = 1'b1;
    set_faults(en);
    run_traffic(20, 4, 1'b0);
    wait_idle();
    hold_low = 1'b1;
    @(negedge clk);
    for (int k = 0; k < 6; k++)
    begin
      send_packet(fmt_cpld, 4);
      assert (pkt_wait_max == 0)
      else
        report_error("afu_ready stalled a dropped completion while the link was stalled");
    end
    wait_idle();
    hold_low = 1'b0;
    check_counter();
    finish_test("cpl_drop");

    // Single beat packets with a gap after each, so every completion shows twice
    start_test();
    en = '0;
    en.cpl_replay = 1'b1;
    set_faults(en);
    run_traffic(12, 1, 1'b1);
    check_counter();
    finish_test("cpl_replay");

    // Several faults at once, the counter sums them over all classes
    start_test();
    en = '0;
    en.mwr_long      = 1'b1;
    en.tag_max       = 1'b1;
    en.cpl_bc_short  = 1'b1;
    en.cpl_len_short = 1'b1;
    set_faults(en);
    run_traffic(20, 4, 1'b0);
    check_counter();
    set_faults('0);
    finish_test("counter");

    wait_idle();
    $display("Summary: %0d tests, %0d failed, %0d beats sent, %0d errors",
             test_count, test_fail, beats_sent, error_count);
    if (error_count == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule
